//--- build.f
rtl/cache_pkg.sv
rtl/cache_store.sv
rtl/banked_mem.sv
rtl/cache_ctrl.sv
rtl/cache_top.sv
tests/cache_tb.sv

//--- Makefile
TOP = cache_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f build.f --top-module $(TOP)

sim:
	verilator --binary --assert -j 0 -f build.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf obj_dir

//--- tests/cache_tb.sv
`timescale 1ns/1ns

module cache_tb;
    import cache_pkg::*;

    localparam int cycle_limit  = 6000;   // 400 requests at up to 13 cycles, plus margin
    localparam int done_limit   = 20;
    localparam int random_count = 400;

    logic              clk       = 1'b0;
    logic              rst       = 1'b1;
    logic              rd        = 1'b0;
    logic              wr        = 1'b0;
    logic [word_w-1:0] addr      = '0;
    logic [word_w-1:0] data_in   = '0;
    logic [word_w-1:0] data_out;
    logic              done;
    logic              stall;
    logic              cache_hit;

    // reference model
    logic [word_w-1:0] mem_model [logic [word_w-2:0]];    // unwritten words read as zero
    logic              line_valid [lines];
    logic [tag_w-1:0]  line_tag [lines];
    logic              line_dirty [lines];

    // expectation for the open request
    logic              exp_wr   = 1'b1;
    logic              exp_hit  = 1'b0;
    logic [word_w-1:0] exp_data = '0;
    int                exp_lat  = 0;

    int                lat;         // cycles since acceptance, 0 while idle
    int                cycles;
    int                requests;
    int                value_errs;
    int                other_errs;

    cache_top dut_i (
        .clk       (clk),
        .rst       (rst),
        .rd        (rd),
        .wr        (wr),
        .addr      (addr),
        .data_in   (data_in),
        .data_out  (data_out),
        .done      (done),
        .stall     (stall),
        .cache_hit (cache_hit)
    );

    always #2 clk = ~clk;

    // a strobe is taken only while no request is open
    always @(posedge clk) begin
        if (rst) begin
            lat <= 0;
        end else if (lat == 0 && (rd || wr)) begin
            lat <= 1;
        end else if (done) begin
            lat <= 0;
        end else if (lat != 0) begin
            lat <= lat + 1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("run stopped at the limit of %0d cycles", cycle_limit);
            $display("Regression failed");
            $finish;
        end
    end

    // ------------------------------
    // checks
    // ------------------------------
    assert property (@(posedge clk) $fell(rst) |-> dut_i.ctrl_i.state == idle)
        else begin
            value_errs++;
            $display("FAILED t=%0t state: expected %0d, got %0d", $time, idle,
                     $sampled(dut_i.ctrl_i.state));
        end

    assert property (@(posedge clk)
        $fell(rst) |-> !dut_i.mem_rd && !dut_i.mem_wr && !dut_i.st_write)
        else begin
            other_errs++;
            $display("t=%0t a memory or store strobe is active right after reset", $time);
        end

    assert property (@(posedge clk) disable iff (rst) lat == 0 |-> !stall && !cache_hit)
        else begin
            other_errs++;
            $display("t=%0t stall or cache_hit is high with no request open", $time);
        end

    assert property (@(posedge clk) disable iff (rst) lat != 0 |-> stall)
        else begin
            other_errs++;
            $display("t=%0t stall is low while a request is open", $time);
        end

    assert property (@(posedge clk) disable iff (rst) done |-> lat != 0)
        else begin
            other_errs++;
            $display("t=%0t done pulse without an accepted request", $time);
        end

    assert property (@(posedge clk) disable iff (rst) done |-> lat == exp_lat)
        else begin
            value_errs++;
            $display("FAILED t=%0t latency: expected %0d, got %0d", $time,
                     $sampled(exp_lat), $sampled(lat));
        end

    assert property (@(posedge clk) disable iff (rst) done |-> cache_hit == exp_hit)
        else begin
            value_errs++;
            $display("FAILED t=%0t cache_hit: expected %0b, got %0b", $time,
                     $sampled(exp_hit), $sampled(cache_hit));
        end

    assert property (@(posedge clk) disable iff (rst) done && !exp_wr |-> data_out == exp_data)
        else begin
            value_errs++;
            $display("FAILED t=%0t data_out: expected %h, got %h", $time,
                     $sampled(exp_data), $sampled(data_out));
        end

    // ------------------------------
    // stimulus
    // ------------------------------
    // hit, clean miss or dirty miss from the line model, then update the model
    task automatic predict(input logic is_wr, input logic [word_w-1:0] a,
                           input logic [word_w-1:0] d);
        cache_addr_u         ua;
        logic [index_w-1:0]  idx;
        logic [word_w-2:0]   key;

        ua.word = a;
        idx     = ua.fields.index;
        key     = a[word_w-1:1];
        if (line_valid[idx] && line_tag[idx] == ua.fields.tag) begin
            exp_hit = 1'b1;
            exp_lat = 2;
        end else begin
            exp_hit = 1'b0;
            exp_lat = (line_valid[idx] && line_dirty[idx]) ? 12 : 8;
        end
        exp_wr = is_wr;
        if (is_wr) begin
            mem_model[key]  = d;
            line_dirty[idx] = 1'b1;
        end else begin
            exp_data = mem_model.exists(key) ? mem_model[key] : '0;
            if (!exp_hit) begin
                line_dirty[idx] = 1'b0;    // fresh fill
            end
        end
        line_valid[idx] = 1'b1;
        line_tag[idx]   = ua.fields.tag;
    endtask

    // one request, optionally with a stray strobe while stalled
    task automatic access(input logic is_wr, input logic [word_w-1:0] a,
                          input logic [word_w-1:0] d, input bit stray);
        int n;
        bit seen;

        predict(is_wr, a, d);
        requests++;
        rd      = !is_wr;
        wr      = is_wr;
        addr    = a;
        data_in = d;
        @(posedge clk);
        #1;
        rd   = 1'b0;
        wr   = 1'b0;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < done_limit) begin
            @(posedge clk);
            #1;
            n++;
            rd = stray && (n == 3);
            if (stray && n == 3) begin
                addr    = ~a;
                data_in = ~d;
            end
            seen = done;
        end
        rd = 1'b0;
        if (!seen) begin
            other_errs++;
            $display("no done within %0d cycles for the request to %h", done_limit, a);
        end
        @(posedge clk);    // back in idle
        #1;
    endtask

    initial begin
        cache_addr_u       ua;
        logic [word_w-1:0] a_addr;
        logic [word_w-1:0] b_addr;

        void'($urandom(35));
        for (int i = 0; i < lines; i++) begin
            line_valid[i] = 1'b0;
            line_tag[i]   = '0;
            line_dirty[i] = 1'b0;
        end
        requests   = 0;
        value_errs = 0;
        other_errs = 0;

        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (2) @(posedge clk);
        #1;

        // never written, then write and read back as hits
        access(1'b0, 16'h1234, 16'h0000, 1'b0);
        access(1'b1, 16'h1234, 16'hbeef, 1'b0);
        access(1'b0, 16'h1234, 16'h0000, 1'b0);

        // A and B share an index
        ua.fields.tag    = 5'd3;
        ua.fields.index  = 8'h40;
        ua.fields.offset = 3'd2;
        a_addr           = ua.word;
        ua.fields.tag    = 5'd7;
        ua.fields.offset = 3'd4;
        b_addr           = ua.word;
        access(1'b1, a_addr, 16'h5a5a, 1'b0);
        access(1'b0, b_addr, 16'h0000, 1'b0);    // dirty miss
        access(1'b0, a_addr, 16'h0000, 1'b0);    // comes back through memory

        // strobes while stalled, clean and dirty miss
        access(1'b0, b_addr, 16'h0000, 1'b1);
        access(1'b1, a_addr, 16'hc3c3, 1'b0);
        access(1'b0, b_addr, 16'h0000, 1'b1);
        repeat (4) @(posedge clk);
        #1;

        // ------------------------------
        // random mix
        // ------------------------------
        for (int i = 0; i < random_count; i++) begin
            ua.fields.tag    = 5'($urandom_range(3, 0) * 8 + 1);
            ua.fields.index  = 8'($urandom_range(15, 0) * 16 + 5);
            ua.fields.offset = 3'($urandom_range(7, 0));
            access(1'($urandom_range(1, 0)), ua.word, 16'($urandom), 1'b0);
        end

        repeat (2) @(posedge clk);
        $display("%0d requests, %0d wrong values, %0d other errors",
                 requests, value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- rtl/cache_top.sv
`timescale 1ns/1ns

module cache_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          rd,
    input  logic                          wr,
    input  logic [cache_pkg::word_w-1:0]  addr,
    input  logic [cache_pkg::word_w-1:0]  data_in,
    output logic [cache_pkg::word_w-1:0]  data_out,
    output logic                          done,
    output logic                          stall,
    output logic                          cache_hit
);
    import cache_pkg::*;

    // ------------------------------
    // controller to store
    // ------------------------------
    logic                st_enable;
    logic                st_comp;
    logic                st_write;
    logic                st_valid_in;
    logic [tag_w-1:0]    st_tag_in;
    logic [index_w-1:0]  st_index;
    logic [offset_w-1:0] st_offset;
    logic [word_w-1:0]   st_wdata;
    logic                st_hit;
    logic                st_dirty;
    logic                st_valid;
    logic [tag_w-1:0]    st_tag_out;
    logic [word_w-1:0]   st_rdata;

    // controller to memory
    logic [word_w-1:0]   mem_addr;
    logic [word_w-1:0]   mem_wdata;
    logic [word_w-1:0]   mem_rdata;
    logic                mem_wr;
    logic                mem_rd;

    cache_ctrl ctrl_i (
        .clk         (clk),
        .rst         (rst),
        .rd          (rd),
        .wr          (wr),
        .addr        (addr),
        .data_in     (data_in),
        .stall       (stall),
        .done        (done),
        .cache_hit   (cache_hit),
        .data_out    (data_out),
        .hit         (st_hit),
        .dirty       (st_dirty),
        .valid       (st_valid),
        .tag_out     (st_tag_out),
        .store_rdata (st_rdata),
        .enable      (st_enable),
        .comp        (st_comp),
        .write       (st_write),
        .valid_in    (st_valid_in),
        .tag_in      (st_tag_in),
        .index       (st_index),
        .offset      (st_offset),
        .store_wdata (st_wdata),
        .mem_rdata   (mem_rdata),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_wr      (mem_wr),
        .mem_rd      (mem_rd)
    );

    cache_store store_i (
        .clk      (clk),
        .rst      (rst),
        .enable   (st_enable),
        .comp     (st_comp),
        .write    (st_write),
        .valid_in (st_valid_in),
        .tag_in   (st_tag_in),
        .index    (st_index),
        .offset   (st_offset),
        .data_in  (st_wdata),
        .hit      (st_hit),
        .dirty    (st_dirty),
        .valid    (st_valid),
        .tag_out  (st_tag_out),
        .data_out (st_rdata)
    );

    banked_mem mem_i (
        .clk       (clk),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_wr    (mem_wr),
        .mem_rd    (mem_rd),
        .mem_rdata (mem_rdata)
    );

endmodule

//--- rtl/cache_ctrl.sv
`timescale 1ns/1ns

module cache_ctrl (
    input  logic                            clk,
    input  logic                            rst,
    // host
    input  logic                            rd,
    input  logic                            wr,
    input  logic [cache_pkg::word_w-1:0]    addr,
    input  logic [cache_pkg::word_w-1:0]    data_in,
    output logic                            stall,
    output logic                            done,
    output logic                            cache_hit,
    output logic [cache_pkg::word_w-1:0]    data_out,
    // cache store
    input  logic                            hit,
    input  logic                            dirty,
    input  logic                            valid,
    input  logic [cache_pkg::tag_w-1:0]     tag_out,
    input  logic [cache_pkg::word_w-1:0]    store_rdata,
    output logic                            enable,
    output logic                            comp,
    output logic                            write,
    output logic                            valid_in,
    output logic [cache_pkg::tag_w-1:0]     tag_in,
    output logic [cache_pkg::index_w-1:0]   index,
    output logic [cache_pkg::offset_w-1:0]  offset,
    output logic [cache_pkg::word_w-1:0]    store_wdata,
    // main memory
    input  logic [cache_pkg::word_w-1:0]    mem_rdata,
    output logic [cache_pkg::word_w-1:0]    mem_addr,
    output logic [cache_pkg::word_w-1:0]    mem_wdata,
    output logic                            mem_wr,
    output logic                            mem_rd
);
    import cache_pkg::*;

    ctrl_state_e       state;
    ctrl_state_e       nxt_state;

    cache_addr_u       req_addr;    // latched at acceptance
    logic [word_w-1:0] req_data;
    logic              req_wr;      // 1 for a write request
    logic              hit_q;       // compare result, reported with done
    logic [word_w-1:0] hold;        // read result

    cache_addr_u       mem_au;      // memory address being built
    logic [1:0]        mem_sel;     // line word for evict writes and fill reads
    logic [1:0]        fill_sel;    // line word written back into the store
    logic              accept;
    logic              evicting;
    logic              fill_rd;
    logic              fill_wr;
    logic              merge;       // fill word is the requested one

    assign accept   = (state == idle) && (rd || wr);
    assign evicting = state inside {evict_0, evict_1, evict_2, evict_3};
    assign fill_rd  = state inside {fill_0, fill_1, fill_2, fill_3};
    assign fill_wr  = state inside {fill_2, fill_3, fill_4, fill_5};
    assign merge    = (req_addr.fields.offset[2:1] == fill_sel);

    assign mem_addr = mem_au.word;
    assign data_out = hold;

    // ------------------------------
    // word selects
    // ------------------------------
    always_comb begin
        case (state)
            evict_1, fill_1: mem_sel = 2'd1;
            evict_2, fill_2: mem_sel = 2'd2;
            evict_3, fill_3: mem_sel = 2'd3;
            default:         mem_sel = 2'd0;
        endcase

        // returned words trail the read strobes by two states
        case (state)
            fill_3:  fill_sel = 2'd1;
            fill_4:  fill_sel = 2'd2;
            fill_5:  fill_sel = 2'd3;
            default: fill_sel = 2'd0;
        endcase
    end

    // ------------------------------
    // next state and outputs
    // ------------------------------
    always_comb begin
        nxt_state   = state;
        stall       = 1'b1;
        done        = 1'b0;
        cache_hit   = 1'b0;

        enable      = 1'b0;
        comp        = 1'b0;
        write       = 1'b0;
        valid_in    = 1'b0;
        tag_in      = req_addr.fields.tag;
        index       = req_addr.fields.index;
        offset      = req_addr.fields.offset;
        store_wdata = req_data;

        mem_au.fields.tag    = req_addr.fields.tag;
        mem_au.fields.index  = req_addr.fields.index;
        mem_au.fields.offset = {mem_sel, 1'b0};
        mem_wdata            = store_rdata;
        mem_wr               = evicting;
        mem_rd               = fill_rd;

        case (state)
            idle: begin
                stall = 1'b0;
                if (rd) begin
                    nxt_state = comp_rd;
                end else if (wr) begin
                    nxt_state = comp_wr;
                end
            end

            comp_rd, comp_wr: begin
                enable = 1'b1;
                comp   = 1'b1;
                write  = (state == comp_wr);    // store writes only on a hit
                if (hit) begin
                    nxt_state = done_st;
                end else if (valid && dirty) begin
                    nxt_state = evict_0;
                end else begin
                    nxt_state = fill_0;
                end
            end

            evict_0, evict_1, evict_2, evict_3: begin
                enable            = 1'b1;
                offset            = {mem_sel, 1'b0};
                mem_au.fields.tag = tag_out;     // victim line address
                nxt_state         = ctrl_state_e'(state + 4'd1);
            end

            fill_0, fill_1, fill_2, fill_3, fill_4, fill_5: begin
                if (fill_wr) begin
                    enable      = 1'b1;
                    write       = 1'b1;
                    valid_in    = 1'b1;
                    offset      = {fill_sel, 1'b0};
                    store_wdata = (req_wr && merge) ? req_data : mem_rdata;
                    // a write request leaves the line dirty
                    comp        = (state == fill_5) && req_wr;
                end
                nxt_state = ctrl_state_e'(state + 4'd1);    // fill_5 steps to done_st
            end

            done_st: begin
                done      = 1'b1;
                cache_hit = hit_q;
                nxt_state = idle;
            end

            default: begin
                nxt_state = idle;
            end
        endcase
    end

    // ------------------------------
    // registers
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= idle;
            req_wr <= 1'b0;
            hit_q  <= 1'b0;
        end else begin
            state <= nxt_state;
            if (accept) begin
                req_wr <= !rd;    // rd wins when both strobes are up
            end
            if (state inside {comp_rd, comp_wr}) begin
                hit_q <= hit;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr.word <= addr;
            req_data      <= data_in;
        end
        if (state == comp_rd && hit) begin
            hold <= store_rdata;
        end else if (fill_wr && !req_wr && merge) begin
            hold <= mem_rdata;    // requested word on its way into the store
        end
    end

endmodule

//--- rtl/banked_mem.sv
`timescale 1ns/1ns

module banked_mem (
    input  logic                          clk,
    input  logic [cache_pkg::word_w-1:0]  mem_addr,
    input  logic [cache_pkg::word_w-1:0]  mem_wdata,
    input  logic                          mem_wr,
    input  logic                          mem_rd,
    output logic [cache_pkg::word_w-1:0]  mem_rdata
);
    import cache_pkg::*;

    localparam int banks = 4;
    localparam int row_w = word_w - 3;    // address bits above the bank select
    localparam int rows  = 1 << row_w;

    // ------------------------------
    // storage
    // ------------------------------
    logic [word_w-1:0] bank_mem [banks][rows] = '{default: '0};

    logic [1:0]        bank_sel;
    logic [row_w-1:0]  row_sel;

    assign bank_sel = mem_addr[2:1];        // consecutive words go to different banks
    assign row_sel  = mem_addr[word_w-1:3];

    always_ff @(posedge clk) begin
        if (mem_wr) begin
            bank_mem[bank_sel][row_sel] <= mem_wdata;
        end
    end

    // ------------------------------
    // read pipeline
    // ------------------------------
    logic [1:0]        bank_q1;
    logic [1:0]        bank_q2;
    logic [row_w-1:0]  row_q1;
    logic [row_w-1:0]  row_q2;

    // stage 1 takes a new address on each strobe, stage 2 always follows
    always_ff @(posedge clk) begin
        if (mem_rd) begin
            bank_q1 <= bank_sel;
            row_q1  <= row_sel;
        end
        bank_q2 <= bank_q1;
        row_q2  <= row_q1;
    end

    // data two cycles after the strobe
    assign mem_rdata = bank_mem[bank_q2][row_q2];

endmodule

//--- rtl/cache_store.sv
`timescale 1ns/1ns

module cache_store (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            enable,
    input  logic                            comp,
    input  logic                            write,
    input  logic                            valid_in,
    input  logic [cache_pkg::tag_w-1:0]     tag_in,
    input  logic [cache_pkg::index_w-1:0]   index,
    input  logic [cache_pkg::offset_w-1:0]  offset,
    input  logic [cache_pkg::word_w-1:0]    data_in,
    output logic                            hit,
    output logic                            dirty,
    output logic                            valid,
    output logic [cache_pkg::tag_w-1:0]     tag_out,
    output logic [cache_pkg::word_w-1:0]    data_out
);
    import cache_pkg::*;

    localparam int words = lines * 4;

    // ------------------------------
    // line state and data
    // ------------------------------
    logic [tag_w-1:0]   tag_mem [lines];
    logic [lines-1:0]   valid_mem;
    logic [lines-1:0]   dirty_mem;
    logic [word_w-1:0]  data_mem [words];

    logic [index_w+1:0] word_idx;   // line index plus word within the line
    logic               cmp_we;
    logic               fill_we;
    logic               data_we;

    assign word_idx = {index, offset[2:1]};

    // combinational lookup
    assign tag_out  = tag_mem[index];
    assign valid    = valid_mem[index];
    assign dirty    = dirty_mem[index];
    assign hit      = valid && (tag_out == tag_in);
    assign data_out = data_mem[word_idx];

    // compare write lands only on a hit, fill write always lands
    assign cmp_we  = enable && write && comp && hit;
    assign fill_we = enable && write && !comp;
    assign data_we = cmp_we || fill_we;

    // ------------------------------
    // tag, valid, dirty update
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_mem <= '0;
            dirty_mem <= '0;
            for (int i = 0; i < lines; i++) begin
                tag_mem[i] <= '0;
            end
        end else if (fill_we) begin
            tag_mem[index]   <= tag_in;
            valid_mem[index] <= valid_in;
            dirty_mem[index] <= 1'b0;    // fresh copy of memory
        end else if (cmp_we) begin
            dirty_mem[index] <= 1'b1;
        end
    end

    // data array
    always_ff @(posedge clk) begin
        if (data_we) begin
            data_mem[word_idx] <= data_in;
        end
    end

endmodule

//--- rtl/cache_pkg.sv
package cache_pkg;

    // ------------------------------
    // address format
    // ------------------------------
    localparam int word_w   = 16;
    localparam int tag_w    = 5;
    localparam int index_w  = 8;
    localparam int offset_w = 3;    // byte offset, bit 0 unused
    localparam int lines    = 256;

    // one 16-bit address seen either as a plain word or split into its fields
    typedef union packed {
        logic [word_w-1:0] word;
        struct packed {
            logic [tag_w-1:0]    tag;
            logic [index_w-1:0]  index;
            logic [offset_w-1:0] offset;
        } fields;
    } cache_addr_u;

    // ------------------------------
    // controller states
    // ------------------------------
    // evict and fill states are consecutive codes
    typedef enum logic [3:0] {
        idle, comp_rd, comp_wr,
        evict_0, evict_1, evict_2, evict_3,
        fill_0, fill_1, fill_2, fill_3, fill_4, fill_5,
        done_st
    } ctrl_state_e;

endpackage
